// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove obj_dir and the log"

test:
	verilator --binary --timing --assert --top-module nes_loader_tb -f nes_loader.f
	./obj_dir/Vnes_loader_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== nes_loader.f ====
source/nes_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/rom_loader.sv
source/cpu_bus_map.sv
source/nes_loader_top.sv
test/nes_loader_props.sv
test/nes_loader_tb.sv

// ==== source/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_valid,
    input  logic [7:0]         rx_data,
    output logic               prg_valid,
    output nes_pkg::prg_byte_t prg_entry,
    input  logic               credit_ret,
    output logic               overrun
);

    logic [7:0]                  mem [nes_pkg::FIFO_DEPTH];
    logic [nes_pkg::FIFO_AW-1:0] wr_ptr;
    logic [nes_pkg::FIFO_AW-1:0] rd_ptr;
    logic [nes_pkg::FIFO_CW-1:0] count;
    logic [nes_pkg::CRED_W-1:0]  credits;      // Free slots in the loader
    logic [nes_pkg::ROM_AW-1:0]  sent_cnt;     // Position within the image

    wire full = (count == nes_pkg::FIFO_CW'(nes_pkg::FIFO_DEPTH));
    wire push = rx_valid && !full;           // Receiver cannot stall, drop instead
    wire send = (count != '0) && (credits != '0);
    wire at_last = (sent_cnt == nes_pkg::ROM_AW'(nes_pkg::PRG_LEN - 1));

    // Head entry goes out as soon as a credit is available
    assign prg_valid      = send;
    assign prg_entry.data = mem[rd_ptr];
    assign prg_entry.last = at_last;

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= rx_data;
    end

    // ------------------------------
    // Pointers, fill level, credits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credits  <= nes_pkg::CRED_W'(nes_pkg::LOADER_CREDITS);
            sent_cnt <= '0;
            overrun  <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            if (send) rd_ptr <= rd_ptr + 1'b1;

            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // One credit per send, one back per retired entry
            case ({send, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            if (send) sent_cnt <= at_last ? '0 : sent_cnt + 1'b1;

            if (rx_valid && full) overrun <= 1'b1;   // Sticky
        end
    end

endmodule

// ==== source/cpu_bus_map.sv ====
`timescale 1ns/1ps

module cpu_bus_map (
    input  logic                       clk,
    input  logic                       rst,
    input  nes_pkg::bus_req_t          bus_req,
    output logic [7:0]                 bus_rdata,
    input  logic [7:0]                 ppu_rdata,
    output logic                       ppu_wr,
    output logic [nes_pkg::PPU_AW-1:0] ppu_addr,
    output logic [7:0]                 ppu_wdata,
    input  logic                       rom_wr_req,
    input  logic [nes_pkg::ROM_AW-1:0] rom_wr_addr,
    input  logic [7:0]                 rom_wr_data,
    output logic                       rom_wr_ack
);

    logic [7:0] sram_mem [2**nes_pkg::SRAM_AW];
    logic [7:0] rom_mem  [nes_pkg::PRG_LEN];

    nes_pkg::region_t region;
    nes_pkg::region_t rd_region;   // Region of last cycle's read

    logic [7:0] sram_q;
    logic [7:0] rom_q;
    logic [7:0] ppu_q;

    // ------------------------------
    // Address decode
    // ------------------------------
    always_comb begin
        if (bus_req.addr < nes_pkg::SRAM_END)      region = nes_pkg::SRAM;
        else if (bus_req.addr < nes_pkg::PPU_END)  region = nes_pkg::PPU;
        else if (bus_req.addr >= nes_pkg::ROM_BASE) region = nes_pkg::ROM;
        else                                       region = nes_pkg::NONE;
    end

    // Mirroring falls out of the truncated indexes
    wire [nes_pkg::SRAM_AW-1:0] sram_idx = bus_req.addr[nes_pkg::SRAM_AW-1:0];
    wire [nes_pkg::ROM_AW-1:0]  rom_idx  = bus_req.addr[nes_pkg::ROM_AW-1:0];

    wire sram_wr = bus_req.wr && (region == nes_pkg::SRAM);
    wire rom_rd  = bus_req.rd && (region == nes_pkg::ROM);

    // CPU read owns the single ROM port
    assign rom_wr_ack = rom_wr_req && !rom_rd;

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (sram_wr) sram_mem[sram_idx] <= bus_req.wdata;   // Seen next cycle
        sram_q <= sram_mem[sram_idx];
    end

    // One port, read or write per cycle
    always_ff @(posedge clk) begin
        if (rom_rd)          rom_q <= rom_mem[rom_idx];
        else if (rom_wr_ack) rom_mem[rom_wr_addr] <= rom_wr_data;
    end

    always_ff @(posedge clk) begin
        ppu_q <= ppu_rdata;   // Value in the request cycle
    end

    // ------------------------------
    // Read select and PPU port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_region <= nes_pkg::NONE;
            ppu_wr    <= 1'b0;
        end else begin
            rd_region <= region;
            ppu_wr    <= bus_req.wr && (region == nes_pkg::PPU);
        end
    end

    // Write triple lands one cycle after the request
    always_ff @(posedge clk) begin
        ppu_addr  <= bus_req.addr[nes_pkg::PPU_AW-1:0];
        ppu_wdata <= bus_req.wdata;
    end

    always_comb begin
        case (rd_region)
            nes_pkg::SRAM: bus_rdata = sram_q;
            nes_pkg::PPU:  bus_rdata = ppu_q;
            nes_pkg::ROM:  bus_rdata = rom_q;
            default:       bus_rdata = 8'h00;   // Unmapped
        endcase
    end

endmodule

// ==== source/nes_loader_top.sv ====
`timescale 1ns/1ps

module nes_loader_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx,
    input  nes_pkg::bus_req_t          bus_req,
    output logic [7:0]                 bus_rdata,
    input  logic [7:0]                 ppu_rdata,
    output logic                       ppu_wr,
    output logic [nes_pkg::PPU_AW-1:0] ppu_addr,
    output logic [7:0]                 ppu_wdata,
    output logic                       cpu_reset,
    output logic                       load_done,
    output logic                       overrun,
    output logic                       frame_err
);

    // ------------------------------
    // Load path
    // ------------------------------
    logic                       rx_valid;
    logic [7:0]                 rx_data;
    logic                       prg_valid;
    nes_pkg::prg_byte_t         prg_entry;
    logic                       credit_ret;
    logic                       rom_wr_req;
    logic [nes_pkg::ROM_AW-1:0] rom_wr_addr;
    logic [7:0]                 rom_wr_data;
    logic                       rom_wr_ack;

    uart_rx u_rx (
        .clk(clk), .rst(rst), .rx(rx),
        .rx_valid(rx_valid), .rx_data(rx_data), .frame_err(frame_err)
    );

    byte_fifo u_fifo (
        .clk(clk), .rst(rst),
        .rx_valid(rx_valid), .rx_data(rx_data),
        .prg_valid(prg_valid), .prg_entry(prg_entry),
        .credit_ret(credit_ret), .overrun(overrun)
    );

    rom_loader u_loader (
        .clk(clk), .rst(rst),
        .prg_valid(prg_valid), .prg_entry(prg_entry), .credit_ret(credit_ret),
        .rom_wr_req(rom_wr_req), .rom_wr_addr(rom_wr_addr),
        .rom_wr_data(rom_wr_data), .rom_wr_ack(rom_wr_ack),
        .cpu_reset(cpu_reset), .load_done(load_done)
    );

    // CPU side memory map
    cpu_bus_map u_map (
        .clk(clk), .rst(rst),
        .bus_req(bus_req), .bus_rdata(bus_rdata), .ppu_rdata(ppu_rdata),
        .ppu_wr(ppu_wr), .ppu_addr(ppu_addr), .ppu_wdata(ppu_wdata),
        .rom_wr_req(rom_wr_req), .rom_wr_addr(rom_wr_addr),
        .rom_wr_data(rom_wr_data), .rom_wr_ack(rom_wr_ack)
    );

endmodule

// ==== source/nes_pkg.sv ====
package nes_pkg;

    // ------------------------------
    // Serial line
    // ------------------------------
    localparam int CLKS_PER_BIT = 16;                 // System clocks per UART bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;   // Start edge to mid start bit
    localparam int BIT_CW       = $clog2(CLKS_PER_BIT);

    // ------------------------------
    // Program image and memories
    // ------------------------------
    localparam int PRG_LEN = 1024;                    // Bytes per ROM image
    localparam int ROM_AW  = 10;                      // Covers PRG_LEN
    localparam int SRAM_AW = 11;                      // 2 KB work RAM
    localparam int PPU_AW  = 3;                       // Eight PPU registers, mirrored

    // Region boundaries on the CPU side
    localparam logic [15:0] SRAM_END = 16'h2000;      // 0000-1FFF SRAM, mirrored
    localparam logic [15:0] PPU_END  = 16'h4000;      // 2000-3FFF PPU registers
    localparam logic [15:0] ROM_BASE = 16'h8000;      // 8000-FFFF program ROM

    // ------------------------------
    // FIFO and credit link
    // ------------------------------
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_AW        = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW        = FIFO_AW + 1;      // Count reaches FIFO_DEPTH
    localparam int LOADER_CREDITS = 2;                // Loader queue slots
    localparam int CRED_W         = $clog2(LOADER_CREDITS + 1);
    localparam int LQ_AW          = $clog2(LOADER_CREDITS);

    // One entry on the FIFO to loader link
    typedef struct packed {
        logic [7:0] data;
        logic       last;                             // Final byte of the image
    } prg_byte_t;

    // CPU bus request, valid for one cycle
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } bus_req_t;

    // Decoded region of a CPU address
    typedef enum logic [1:0] {
        SRAM = 2'd0,
        PPU  = 2'd1,
        ROM  = 2'd2,
        NONE = 2'd3                                   // 4000-7FFF, reads as zero
    } region_t;

endpackage

// ==== source/rom_loader.sv ====
`timescale 1ns/1ps

module rom_loader (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       prg_valid,
    input  nes_pkg::prg_byte_t         prg_entry,
    output logic                       credit_ret,
    output logic                       rom_wr_req,
    output logic [nes_pkg::ROM_AW-1:0] rom_wr_addr,
    output logic [7:0]                 rom_wr_data,
    input  logic                       rom_wr_ack,
    output logic                       cpu_reset,
    output logic                       load_done
);

    // ------------------------------
    // Holding queue, one slot per credit
    // ------------------------------
    nes_pkg::prg_byte_t          q_mem [nes_pkg::LOADER_CREDITS];
    logic [nes_pkg::LQ_AW-1:0]   q_wp;
    logic [nes_pkg::LQ_AW-1:0]   q_rp;
    logic [nes_pkg::CRED_W-1:0]  q_cnt;
    logic [nes_pkg::ROM_AW-1:0]  wr_addr;      // Next ROM offset

    nes_pkg::prg_byte_t head;

    assign head = q_mem[q_rp];

    wire wr_fire   = rom_wr_req && rom_wr_ack;   // Entry retired this cycle
    wire done_fire = wr_fire && head.last;
    // Another image already underway behind the last byte
    wire more      = prg_valid || (q_cnt > nes_pkg::CRED_W'(1));

    assign rom_wr_req  = (q_cnt != '0);   // Held until the bus map acks
    assign rom_wr_addr = wr_addr;
    assign rom_wr_data = head.data;

    always_ff @(posedge clk) begin
        if (prg_valid) q_mem[q_wp] <= prg_entry;   // Credits guarantee room
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wp       <= '0;
            q_rp       <= '0;
            q_cnt      <= '0;
            wr_addr    <= '0;
            credit_ret <= 1'b0;
            cpu_reset  <= 1'b0;
            load_done  <= 1'b0;
        end else begin
            if (prg_valid) q_wp <= q_wp + 1'b1;
            if (wr_fire)   q_rp <= q_rp + 1'b1;

            case ({prg_valid, wr_fire})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase

            credit_ret <= wr_fire;   // Cycle after the ack

            // Address restarts with each image
            if (wr_fire) wr_addr <= head.last ? '0 : wr_addr + 1'b1;

            if (prg_valid) cpu_reset <= 1'b1;   // Hold CPU while loading
            if (done_fire) begin
                cpu_reset <= more;
                load_done <= 1'b1;              // Stays set until rst
            end
        end
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       rx_valid,
    output logic [7:0] rx_data,
    output logic       frame_err
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t state;

    logic [1:0]                    rx_sync;    // Two-flop synchronizer
    logic                          rx_prev;    // For the falling edge
    logic [nes_pkg::BIT_CW-1:0]    bit_cnt;    // Clocks left to next sample
    logic [2:0]                    bit_idx;
    logic [7:0]                    shreg;

    wire rx_s      = rx_sync[1];
    wire start_edg = rx_prev && !rx_s;
    wire sample    = (bit_cnt == '0);

    // ------------------------------
    // Line synchronizer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;                  // Line idles high
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_s;
        end
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_valid <= 1'b0;                  // Single-cycle strobe
            case (state)
                IDLE: begin
                    if (start_edg) begin
                        state   <= START;
                        bit_cnt <= nes_pkg::BIT_CW'(nes_pkg::HALF_BIT - 1);
                    end
                end
                START: begin
                    if (!sample) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end else if (!rx_s) begin  // Still low at mid start bit
                        state   <= DATA;
                        bit_cnt <= nes_pkg::BIT_CW'(nes_pkg::CLKS_PER_BIT - 1);
                        bit_idx <= '0;
                    end else begin
                        state <= IDLE;         // Glitch, not a frame
                    end
                end
                DATA: begin
                    if (!sample) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end else begin
                        bit_cnt <= nes_pkg::BIT_CW'(nes_pkg::CLKS_PER_BIT - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (!sample) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end else begin
                        // Mid stop bit, 9.5 bits after the start edge
                        if (rx_s) rx_valid  <= 1'b1;
                        else      frame_err <= 1'b1;   // Sticky until rst
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && sample) shreg <= {rx_s, shreg[7:1]};
        if (state == STOP && sample) rx_data <= shreg;
    end

endmodule

// ==== test/nes_loader_props.sv ====
`timescale 1ns/1ps

module nes_loader_props (
    input logic                       clk,
    input logic                       rst,
    input logic                       prg_valid,
    input logic                       credit_ret,
    input logic                       overrun,
    input logic [nes_pkg::CRED_W-1:0] credits
);

    int unsigned fail_cnt = 0;   // Seen by the testbench at the end

    // Entries sent and not yet retired by the loader
    logic [nes_pkg::CRED_W-1:0] in_flight;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({prg_valid, credit_ret})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // Never more credits than loader slots
    cred_max: assert property (@(posedge clk) disable iff (rst)
        credits <= nes_pkg::CRED_W'(nes_pkg::LOADER_CREDITS))
        else begin
            fail_cnt++;
            $error("FIFO credit count above the loader queue size");
        end

    // A send needs a free slot in the loader queue
    send_has_credit: assert property (@(posedge clk) disable iff (rst)
        prg_valid |-> (in_flight < nes_pkg::CRED_W'(nes_pkg::LOADER_CREDITS)))
        else begin
            fail_cnt++;
            $error("prg_valid high with zero credits");
        end

    quiet_after_rst: assert property (@(posedge clk) rst |=> (!prg_valid && !overrun))
        else begin
            fail_cnt++;
            $error("prg_valid or overrun high in the cycle after reset");
        end

endmodule

bind byte_fifo nes_loader_props props (
    .clk(clk), .rst(rst), .prg_valid(prg_valid), .credit_ret(credit_ret),
    .overrun(overrun), .credits(credits)
);

// ==== test/nes_loader_tb.sv ====
`timescale 1ns/1ps

module nes_loader_tb;

    typedef enum logic {OP_WR, OP_RD} op_t;
    typedef enum int {CPU_RESET, LOAD_DONE, OVERRUN, FRAME_ERR} flag_t;

    // One row of the bus table
    typedef struct packed {
        op_t              op;
        logic [15:0]      addr;
        logic [7:0]       wdata;
        logic [7:0]       prd;      // ppu_rdata in the request cycle
        nes_pkg::region_t region;   // Expected decode
    } bus_row_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       rx;
    nes_pkg::bus_req_t          bus_req;
    logic [7:0]                 bus_rdata;
    logic [7:0]                 ppu_rdata;
    logic                       ppu_wr;
    logic [nes_pkg::PPU_AW-1:0] ppu_addr;
    logic [7:0]                 ppu_wdata;
    logic                       cpu_reset;
    logic                       load_done;
    logic                       overrun;
    logic                       frame_err;

    integer     seed = 70605;
    logic [7:0] image1      [nes_pkg::PRG_LEN];
    logic [7:0] image2      [nes_pkg::PRG_LEN];
    logic [7:0] rom_model   [nes_pkg::PRG_LEN];      // Expected ROM contents
    logic [7:0] sram_shadow [2**nes_pkg::SRAM_AW];
    bus_row_t   rows        [20];
    logic       reads_stop;                          // Ends the stall reads

    nes_loader_top UUT (
        .clk(clk), .rst(rst), .rx(rx),
        .bus_req(bus_req), .bus_rdata(bus_rdata), .ppu_rdata(ppu_rdata),
        .ppu_wr(ppu_wr), .ppu_addr(ppu_addr), .ppu_wdata(ppu_wdata),
        .cpu_reset(cpu_reset), .load_done(load_done),
        .overrun(overrun), .frame_err(frame_err)
    );

    always #10 clk = ~clk;   // 20 ns period

    // ------------------------------
    // Compare and wait helpers
    // ------------------------------
    task abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %02h expected %02h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task check_ppu(input logic got_wr, input logic [nes_pkg::PPU_AW-1:0] got_addr,
                   input logic [7:0] got_data, input logic exp_wr,
                   input logic [nes_pkg::PPU_AW-1:0] exp_addr, input logic [7:0] exp_data);
        if (got_wr !== exp_wr || (exp_wr && (got_addr !== exp_addr || got_data !== exp_data)))
        begin
            $display("CHECK FAILED at %0t: ppu write, got %b/%0d/%02h expected %b/%0d/%02h",
                     $time, got_wr, got_addr, got_data, exp_wr, exp_addr, exp_data);
            abort_run();
        end
    endtask

    function automatic logic flag_value(input flag_t f);
        case (f)
            CPU_RESET: return cpu_reset;
            LOAD_DONE: return load_done;
            OVERRUN:   return overrun;
            default:   return frame_err;
        endcase
    endfunction

    // Polls on falling edges until the flag is high
    task wait_flag(input flag_t f, input int max_cycles, input string what);
        int n;
        n = 0;
        while (flag_value(f) !== 1'b1) begin
            if (n == max_cycles) begin
                $display("Timeout: %s did not go high within %0d cycles", what, max_cycles);
                abort_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // ------------------------------
    // Stimulus drivers
    // ------------------------------
    task send_frame(input logic [7:0] data, input logic stop_bit);   // 8N1, LSB first
        int b;
        rx = 1'b0;
        repeat (nes_pkg::CLKS_PER_BIT) @(negedge clk);
        for (b = 0; b < 8; b++) begin
            rx = data[b];
            repeat (nes_pkg::CLKS_PER_BIT) @(negedge clk);
        end
        rx = stop_bit;
        repeat (nes_pkg::CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;   // Back to idle
    endtask

    // One request cycle, returns where bus_rdata is valid
    task bus_cycle(input logic rd, input logic wr, input logic [15:0] addr,
                   input logic [7:0] wdata, input logic [7:0] prd);
        bus_req   = {rd, wr, addr, wdata};
        ppu_rdata = prd;
        @(negedge clk);
        bus_req   = '0;
        ppu_rdata = ~prd;   // Later value must not show up
    endtask

    // Reads one ROM offset, an idle cycle between polls lets the loader write
    task wait_rom_byte(input logic [nes_pkg::ROM_AW-1:0] off, input logic [7:0] exp,
                       input int max_polls);
        int n;
        n = 0;
        bus_cycle(1'b1, 1'b0, nes_pkg::ROM_BASE | 16'(off), 8'h00, 8'h00);
        while (bus_rdata !== exp) begin
            if (n == max_polls) begin
                $display("Timeout: ROM offset %0d never received its byte", off);
                abort_run();
            end
            @(negedge clk);
            bus_cycle(1'b1, 1'b0, nes_pkg::ROM_BASE | 16'(off), 8'h00, 8'h00);
            n++;
        end
    endtask

    // Every offset once, spread over the 32 mirrors
    task check_rom_all(input string what);
        int i;
        logic [15:0] addr;
        for (i = 0; i < nes_pkg::PRG_LEN; i++) begin
            addr = nes_pkg::ROM_BASE | 16'(((i * 7) % 32) << 10) | 16'(i);
            bus_cycle(1'b1, 1'b0, addr, 8'h00, 8'h00);
            check_byte($sformatf("%s at %04h", what, addr), bus_rdata, rom_model[i]);
        end
    endtask

    // ROM read in every cycle, checked one cycle later
    task stall_reads();
        int n;
        logic [15:0] addr;
        n = 0;
        while (!reads_stop) begin
            if (n == 4000) begin
                $display("Timeout: overrun never rose during the stall reads");
                abort_run();
            end
            addr    = nes_pkg::ROM_BASE | 16'(n * 13);
            bus_req = {1'b1, 1'b0, addr, 8'h00};
            @(negedge clk);
            check_byte("read during stall", bus_rdata, rom_model[addr[nes_pkg::ROM_AW-1:0]]);
            n++;
        end
        bus_req = '0;
    endtask

    // ------------------------------
    // Bus table
    // ------------------------------
    task fill_table();
        rows[0]  = '{OP_WR, 16'h0012, 8'hA5, 8'h00, nes_pkg::SRAM};
        rows[1]  = '{OP_RD, 16'h0012, 8'h00, 8'h00, nes_pkg::SRAM};
        rows[2]  = '{OP_RD, 16'h0812, 8'h00, 8'h00, nes_pkg::SRAM};   // Mirrors
        rows[3]  = '{OP_RD, 16'h1812, 8'h00, 8'h00, nes_pkg::SRAM};
        rows[4]  = '{OP_WR, 16'h07FF, 8'h3C, 8'h00, nes_pkg::SRAM};
        rows[5]  = '{OP_RD, 16'h1FFF, 8'h00, 8'h00, nes_pkg::SRAM};
        rows[6]  = '{OP_WR, 16'h1000, 8'hC7, 8'h00, nes_pkg::SRAM};
        rows[7]  = '{OP_RD, 16'h0000, 8'h00, 8'h00, nes_pkg::SRAM};
        rows[8]  = '{OP_RD, 16'h4000, 8'h00, 8'h00, nes_pkg::NONE};
        rows[9]  = '{OP_WR, 16'h5555, 8'h77, 8'h00, nes_pkg::NONE};   // Ignored
        rows[10] = '{OP_RD, 16'h5555, 8'h00, 8'h00, nes_pkg::NONE};
        rows[11] = '{OP_RD, 16'h7FFF, 8'h00, 8'h00, nes_pkg::NONE};
        rows[12] = '{OP_WR, 16'h8005, ~image1[5], 8'h00, nes_pkg::ROM};   // ROM stays
        rows[13] = '{OP_RD, 16'h8005, 8'h00, 8'h00, nes_pkg::ROM};
        rows[14] = '{OP_RD, 16'hC405, 8'h00, 8'h00, nes_pkg::ROM};
        rows[15] = '{OP_WR, 16'h2003, 8'h96, 8'h00, nes_pkg::PPU};
        rows[16] = '{OP_WR, 16'h3FFE, 8'h41, 8'h00, nes_pkg::PPU};
        rows[17] = '{OP_RD, 16'h2002, 8'h00, 8'h5A, nes_pkg::PPU};
        rows[18] = '{OP_RD, 16'h3FF9, 8'h00, 8'hC3, nes_pkg::PPU};
        rows[19] = '{OP_RD, 16'h0812, 8'h00, 8'h00, nes_pkg::SRAM};
    endtask

    function automatic logic [7:0] expect_read(input bus_row_t row);
        case (row.region)
            nes_pkg::SRAM: return sram_shadow[row.addr[nes_pkg::SRAM_AW-1:0]];
            nes_pkg::PPU:  return row.prd;
            nes_pkg::ROM:  return rom_model[row.addr[nes_pkg::ROM_AW-1:0]];
            default:       return 8'h00;
        endcase
    endfunction

    task run_table();
        int r;
        for (r = 0; r < $size(rows); r++) begin
            bus_cycle(rows[r].op == OP_RD, rows[r].op == OP_WR, rows[r].addr,
                      rows[r].wdata, rows[r].prd);
            if (rows[r].op == OP_RD) begin
                check_byte($sformatf("row %0d read %04h", r, rows[r].addr),
                           bus_rdata, expect_read(rows[r]));
                check_ppu(ppu_wr, ppu_addr, ppu_wdata, 1'b0, '0, 8'h00);
            end else begin
                if (rows[r].region == nes_pkg::SRAM)
                    sram_shadow[rows[r].addr[nes_pkg::SRAM_AW-1:0]] = rows[r].wdata;
                check_ppu(ppu_wr, ppu_addr, ppu_wdata, rows[r].region == nes_pkg::PPU,
                          rows[r].addr[nes_pkg::PPU_AW-1:0], rows[r].wdata);
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int i;
        rst        = 1'b1;
        rx         = 1'b1;
        bus_req    = '0;
        ppu_rdata  = 8'h00;
        reads_stop = 1'b0;
        for (i = 0; i < nes_pkg::PRG_LEN; i++) begin
            image1[i] = 8'($random(seed));
            image2[i] = 8'($random(seed));
            if (image2[i] == image1[i]) image2[i] = ~image1[i];   // Every offset differs
        end
        fill_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_flag("cpu_reset after reset", cpu_reset, 1'b0);
        check_flag("load_done after reset", load_done, 1'b0);
        check_flag("overrun after reset", overrun, 1'b0);
        check_flag("frame_err after reset", frame_err, 1'b0);

        // First image at line rate, no bus traffic
        send_frame(image1[0], 1'b1);
        wait_flag(CPU_RESET, 32, "cpu_reset");
        for (i = 1; i < nes_pkg::PRG_LEN; i++) send_frame(image1[i], 1'b1);
        wait_flag(LOAD_DONE, 100, "load_done");
        check_flag("cpu_reset after load", cpu_reset, 1'b0);
        check_flag("overrun after load", overrun, 1'b0);
        for (i = 0; i < nes_pkg::PRG_LEN; i++) rom_model[i] = image1[i];
        check_rom_all("image 1");

        run_table();   // SRAM, unmapped and PPU accesses

        // Second image against continuous ROM reads
        fork
            begin
                for (i = 0; i < 10; i++) send_frame(image2[i], 1'b1);
                check_flag("overrun with queue and FIFO full", overrun, 1'b0);
                send_frame(image2[10], 1'b1);   // One byte past FIFO and loader queue
                wait_flag(OVERRUN, 400, "overrun");
                reads_stop = 1'b1;
            end
            stall_reads();
        join
        wait_rom_byte(10'd9, image2[9], 200);   // Last stored byte
        for (i = 0; i < 10; i++) rom_model[i] = image2[i];
        check_rom_all("image 2 stored part");

        // Bad stop bit, then a good frame must land at the next offset
        check_flag("frame_err before bad frame", frame_err, 1'b0);
        send_frame(~image2[10], 1'b0);
        wait_flag(FRAME_ERR, 32, "frame_err");
        repeat (nes_pkg::CLKS_PER_BIT) @(negedge clk);   // Line idle
        send_frame(image2[10], 1'b1);
        wait_rom_byte(10'd10, image2[10], 200);
        rom_model[10] = image2[10];
        bus_cycle(1'b1, 1'b0, nes_pkg::ROM_BASE | 16'd11, 8'h00, 8'h00);
        check_byte("offset after bad frame", bus_rdata, rom_model[11]);

        if (UUT.u_fifo.props.fail_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", UUT.u_fifo.props.fail_cnt);
            abort_run();
        end
    end

endmodule
